// File: Bender.yml
package:
  name: lsu

sources:
  - common/lsu_pkg.sv
  - design/lsu_dispatch.sv
  - load_queue/load_queue.sv
  - store_queue/store_queue.sv
  - design/lsu_mem_ctrl.sv
  - design/lsu.sv
  - target: test
    files:
      - verif/lsu_props.sv
      - verif/tb_lsu.sv

// File: common/lsu_pkg.sv
package lsu_pkg;

    // ============================================================
    // Widths
    // ============================================================

    // Data and address width
    parameter int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // Reorder-buffer slot of an operation
    typedef logic [5:0] rob_idx_t;

    // Physical destination register of a load
    typedef logic [5:0] phys_tag_t;

    // ============================================================
    // Exception causes
    // ============================================================

    // Reported with lsu_exception, one cycle after the handshake
    typedef enum logic [4:0] {
        CAUSE_NONE             = 5'd0,
        CAUSE_LOAD_MISALIGNED  = 5'd1,
        CAUSE_STORE_MISALIGNED = 5'd2
    } exc_cause_t;

endpackage

// File: design/lsu.sv
`timescale 1ns/1ps

module lsu import lsu_pkg::*; #(
    parameter int LQ_ENTRIES = 8,
    parameter int SQ_ENTRIES = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush_pipeline,
    // Allocation from rename
    input  logic       alloc_valid,
    output logic       alloc_ready,
    input  logic       is_load,
    input  word_t      base_addr,
    input  word_t      offset,
    input  phys_tag_t  phys_rd,
    input  rob_idx_t   rob_idx,
    input  word_t      store_data,
    // Store commit from the ROB
    input  logic       commit_en,
    input  rob_idx_t   commit_rob_idx,
    // Common data bus
    output logic       cdb_valid,
    output phys_tag_t  cdb_tag,
    output word_t      cdb_value,
    output logic       cdb_exception,
    // Misalignment exception
    output logic       lsu_exception,
    output exc_cause_t lsu_exception_cause,
    // Scratchpad memory
    output logic       mem_req,
    output logic       mem_we,
    output word_t      mem_addr,
    output word_t      mem_wdata,
    input  logic       mem_ready,
    input  word_t      mem_rdata,
    input  logic       mem_error
);

    // Dispatch to queues
    logic      lq_push;
    word_t     lq_addr;
    phys_tag_t lq_tag;
    logic      lq_full;
    logic      sq_push;
    word_t     sq_addr;
    word_t     sq_data;
    rob_idx_t  sq_rob_idx;
    logic      sq_full;

    // Queue heads to the memory controller
    logic      ld_valid;
    word_t     ld_addr;
    phys_tag_t ld_tag;
    logic      ld_done;
    logic      fwd_hit;
    word_t     fwd_data;
    logic      st_valid;
    word_t     st_addr;
    word_t     st_data;
    logic      st_done;

    lsu_dispatch u_dispatch (
        .clk                 (clk),
        .reset               (reset),
        .flush_pipeline      (flush_pipeline),
        .alloc_valid         (alloc_valid),
        .alloc_ready         (alloc_ready),
        .is_load             (is_load),
        .base_addr           (base_addr),
        .offset              (offset),
        .phys_rd             (phys_rd),
        .rob_idx             (rob_idx),
        .store_data          (store_data),
        .lq_full             (lq_full),
        .sq_full             (sq_full),
        .lq_push             (lq_push),
        .lq_addr             (lq_addr),
        .lq_tag              (lq_tag),
        .sq_push             (sq_push),
        .sq_addr             (sq_addr),
        .sq_data             (sq_data),
        .sq_rob_idx          (sq_rob_idx),
        .lsu_exception       (lsu_exception),
        .lsu_exception_cause (lsu_exception_cause)
    );

    load_queue #(
        .LQ_ENTRIES (LQ_ENTRIES)
    ) u_load_queue (
        .clk            (clk),
        .reset          (reset),
        .flush_pipeline (flush_pipeline),
        .lq_push        (lq_push),
        .lq_addr        (lq_addr),
        .lq_tag         (lq_tag),
        .lq_full        (lq_full),
        .ld_valid       (ld_valid),
        .ld_addr        (ld_addr),
        .ld_tag         (ld_tag),
        .ld_done        (ld_done)
    );

    store_queue #(
        .SQ_ENTRIES (SQ_ENTRIES)
    ) u_store_queue (
        .clk            (clk),
        .reset          (reset),
        .flush_pipeline (flush_pipeline),
        .sq_push        (sq_push),
        .sq_addr        (sq_addr),
        .sq_data        (sq_data),
        .sq_rob_idx     (sq_rob_idx),
        .commit_en      (commit_en),
        .commit_rob_idx (commit_rob_idx),
        .sq_full        (sq_full),
        .fwd_addr       (ld_addr),
        .fwd_hit        (fwd_hit),
        .fwd_data       (fwd_data),
        .st_valid       (st_valid),
        .st_addr        (st_addr),
        .st_data        (st_data),
        .st_done        (st_done)
    );

    lsu_mem_ctrl u_mem_ctrl (
        .clk            (clk),
        .reset          (reset),
        .flush_pipeline (flush_pipeline),
        .ld_valid       (ld_valid),
        .ld_addr        (ld_addr),
        .ld_tag         (ld_tag),
        .fwd_hit        (fwd_hit),
        .fwd_data       (fwd_data),
        .ld_done        (ld_done),
        .st_valid       (st_valid),
        .st_addr        (st_addr),
        .st_data        (st_data),
        .st_done        (st_done),
        .mem_req        (mem_req),
        .mem_we         (mem_we),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_ready      (mem_ready),
        .mem_rdata      (mem_rdata),
        .mem_error      (mem_error),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value),
        .cdb_exception  (cdb_exception)
    );

endmodule

// File: design/lsu_dispatch.sv
`timescale 1ns/1ps

module lsu_dispatch import lsu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush_pipeline,
    input  logic       alloc_valid,
    output logic       alloc_ready,
    input  logic       is_load,
    input  word_t      base_addr,
    input  word_t      offset,
    input  phys_tag_t  phys_rd,
    input  rob_idx_t   rob_idx,
    input  word_t      store_data,
    input  logic       lq_full,
    input  logic       sq_full,
    output logic       lq_push,
    output word_t      lq_addr,
    output phys_tag_t  lq_tag,
    output logic       sq_push,
    output word_t      sq_addr,
    output word_t      sq_data,
    output rob_idx_t   sq_rob_idx,
    output logic       lsu_exception,
    output exc_cause_t lsu_exception_cause
);

    word_t eff_addr;
    logic  misaligned;
    logic  target_full;
    logic  accept;
    logic  active;

    // Effective address, word aligned only
    assign eff_addr    = base_addr + offset;
    assign misaligned  = |eff_addr[1:0];
    assign target_full = is_load ? lq_full : sq_full;

    // A misaligned op never enters a queue, so queue fullness cannot stall it
    assign alloc_ready = active && !flush_pipeline && !(target_full && !misaligned);
    assign accept      = alloc_valid && alloc_ready;

    // Steering to one queue
    assign lq_push    = accept && is_load && !misaligned;
    assign lq_addr    = eff_addr;
    assign lq_tag     = phys_rd;
    assign sq_push    = accept && !is_load && !misaligned;
    assign sq_addr    = eff_addr;
    assign sq_data    = store_data;
    assign sq_rob_idx = rob_idx;

    // One-cycle exception pulse after a misaligned handshake
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active              <= 1'b0;
            lsu_exception       <= 1'b0;
            lsu_exception_cause <= CAUSE_NONE;
        end else begin
            active        <= 1'b1;
            lsu_exception <= accept && misaligned;
            if (accept && misaligned) begin
                lsu_exception_cause <= is_load ? CAUSE_LOAD_MISALIGNED
                                               : CAUSE_STORE_MISALIGNED;
            end else begin
                lsu_exception_cause <= CAUSE_NONE;
            end
        end
    end

endmodule

// File: design/lsu_mem_ctrl.sv
`timescale 1ns/1ps

module lsu_mem_ctrl import lsu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush_pipeline,
    input  logic      ld_valid,
    input  word_t     ld_addr,
    input  phys_tag_t ld_tag,
    input  logic      fwd_hit,
    input  word_t     fwd_data,
    output logic      ld_done,
    input  logic      st_valid,
    input  word_t     st_addr,
    input  word_t     st_data,
    output logic      st_done,
    output logic      mem_req,
    output logic      mem_we,
    output word_t     mem_addr,
    output word_t     mem_wdata,
    input  logic      mem_ready,
    input  word_t     mem_rdata,
    input  logic      mem_error,
    output logic      cdb_valid,
    output phys_tag_t cdb_tag,
    output word_t     cdb_value,
    output logic      cdb_exception
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } state_t;

    state_t    state;
    phys_tag_t rd_tag;
    logic      rd_killed;
    logic      fwd_fire;
    logic      rd_fire;

    // Loads are never served in a flush cycle
    assign fwd_fire = (state == ST_IDLE) && ld_valid && !flush_pipeline && fwd_hit;
    // A flushed read completes on the bus but answers nobody
    assign rd_fire  = (state == ST_READ) && mem_ready && !rd_killed && !flush_pipeline;
    assign ld_done  = fwd_fire || rd_fire;
    assign st_done  = (state == ST_WRITE) && mem_ready;

    // ============================================================
    // Access FSM
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_IDLE;
            mem_req   <= 1'b0;
            mem_we    <= 1'b0;
            rd_killed <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (ld_valid && !flush_pipeline && !fwd_hit) begin
                        state     <= ST_READ;
                        mem_req   <= 1'b1;
                        mem_we    <= 1'b0;
                        mem_addr  <= ld_addr;
                        rd_tag    <= ld_tag;
                        rd_killed <= 1'b0;
                    end else if (!(ld_valid && !flush_pipeline) && st_valid) begin
                        state     <= ST_WRITE;
                        mem_req   <= 1'b1;
                        mem_we    <= 1'b1;
                        mem_addr  <= st_addr;
                        mem_wdata <= st_data;
                    end
                end
                ST_READ: begin
                    if (mem_ready) begin
                        state   <= ST_IDLE;
                        mem_req <= 1'b0;
                    end else if (flush_pipeline) begin
                        rd_killed <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (mem_ready) begin
                        state   <= ST_IDLE;
                        mem_req <= 1'b0;
                        mem_we  <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ============================================================
    // CDB
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cdb_valid     <= 1'b0;
            cdb_exception <= 1'b0;
        end else begin
            cdb_valid     <= ld_done;
            cdb_exception <= rd_fire && mem_error;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_fire) begin
            cdb_tag   <= ld_tag;
            cdb_value <= fwd_data;
        end else if (rd_fire) begin
            cdb_tag   <= rd_tag;
            cdb_value <= mem_rdata;
        end
    end

endmodule

// File: load_queue/load_queue.sv
`timescale 1ns/1ps

module load_queue import lsu_pkg::*; #(
    parameter int LQ_ENTRIES = 8
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush_pipeline,
    input  logic      lq_push,
    input  word_t     lq_addr,
    input  phys_tag_t lq_tag,
    output logic      lq_full,
    output logic      ld_valid,
    output word_t     ld_addr,
    output phys_tag_t ld_tag,
    input  logic      ld_done
);

    localparam int PTR_W = (LQ_ENTRIES > 1) ? $clog2(LQ_ENTRIES) : 1;
    localparam int CNT_W = $clog2(LQ_ENTRIES + 1);

    word_t            addr_q [LQ_ENTRIES];
    phys_tag_t        tag_q  [LQ_ENTRIES];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    // Wrapping increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(LQ_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign lq_full  = (count == CNT_W'(LQ_ENTRIES));
    assign ld_valid = (count != '0);
    assign ld_addr  = addr_q[head];
    assign ld_tag   = tag_q[head];

    // ============================================================
    // Entry storage
    // ============================================================
    always_ff @(posedge clk) begin
        if (lq_push) begin
            addr_q[tail] <= lq_addr;
            tag_q[tail]  <= lq_tag;
        end
    end

    // ============================================================
    // Pointers and occupancy
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_pipeline) begin
            // Every load is speculative
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (lq_push) begin
                tail <= next_ptr(tail);
            end
            if (ld_done) begin
                head <= next_ptr(head);
            end
            count <= count + CNT_W'(lq_push) - CNT_W'(ld_done);
        end
    end

endmodule

// File: lsu.f
common/lsu_pkg.sv
design/lsu_dispatch.sv
load_queue/load_queue.sv
store_queue/store_queue.sv
design/lsu_mem_ctrl.sv
design/lsu.sv
verif/lsu_props.sv
verif/tb_lsu.sv

// File: store_queue/store_queue.sv
`timescale 1ns/1ps

module store_queue import lsu_pkg::*; #(
    parameter int SQ_ENTRIES = 8
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush_pipeline,
    input  logic     sq_push,
    input  word_t    sq_addr,
    input  word_t    sq_data,
    input  rob_idx_t sq_rob_idx,
    input  logic     commit_en,
    input  rob_idx_t commit_rob_idx,
    output logic     sq_full,
    input  word_t    fwd_addr,
    output logic     fwd_hit,
    output word_t    fwd_data,
    output logic     st_valid,
    output word_t    st_addr,
    output word_t    st_data,
    input  logic     st_done
);

    localparam int PTR_W = (SQ_ENTRIES > 1) ? $clog2(SQ_ENTRIES) : 1;
    localparam int CNT_W = $clog2(SQ_ENTRIES + 1);

    word_t            addr_q [SQ_ENTRIES];
    word_t            data_q [SQ_ENTRIES];
    rob_idx_t         rob_q  [SQ_ENTRIES];
    logic [SQ_ENTRIES-1:0] valid;
    logic [SQ_ENTRIES-1:0] committed;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] n_committed;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(SQ_ENTRIES - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign sq_full = (count == CNT_W'(SQ_ENTRIES));

    // Only a committed head may drain
    assign st_valid = valid[head] && committed[head];
    assign st_addr  = addr_q[head];
    assign st_data  = data_q[head];

    // Committed entries form a run from head, so walking from head
    // leaves the youngest match last
    always_comb begin
        int idx;
        fwd_hit  = 1'b0;
        fwd_data = '0;
        for (int k = 0; k < SQ_ENTRIES; k++) begin
            idx = (int'(head) + k) % SQ_ENTRIES;
            if (valid[idx] && committed[idx] && addr_q[idx] == fwd_addr) begin
                fwd_hit  = 1'b1;
                fwd_data = data_q[idx];
            end
        end
    end

    // Length of the committed run, kept on flush
    always_comb begin
        n_committed = '0;
        for (int i = 0; i < SQ_ENTRIES; i++) begin
            n_committed = n_committed + CNT_W'(committed[i]);
        end
    end

    // ============================================================
    // Entry storage
    // ============================================================
    always_ff @(posedge clk) begin
        if (sq_push) begin
            addr_q[tail] <= sq_addr;
            data_q[tail] <= sq_data;
            rob_q[tail]  <= sq_rob_idx;
        end
    end

    // ============================================================
    // Valid and committed flags, pointers
    // ============================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid     <= '0;
            committed <= '0;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
        end else begin
            if (flush_pipeline) begin
                valid <= valid & committed;
                tail  <= PTR_W'((int'(head) + int'(n_committed)) % SQ_ENTRIES);
                count <= n_committed - CNT_W'(st_done);
            end else begin
                if (sq_push) begin
                    valid[tail]     <= 1'b1;
                    committed[tail] <= 1'b0;
                    tail            <= next_ptr(tail);
                end
                if (commit_en) begin
                    for (int i = 0; i < SQ_ENTRIES; i++) begin
                        if (valid[i] && !committed[i] && rob_q[i] == commit_rob_idx) begin
                            committed[i] <= 1'b1;
                        end
                    end
                end
                count <= count + CNT_W'(sq_push) - CNT_W'(st_done);
            end
            // Written to memory, the entry is free
            if (st_done) begin
                valid[head]     <= 1'b0;
                committed[head] <= 1'b0;
                head            <= next_ptr(head);
            end
        end
    end

endmodule

// File: verif/lsu_props.sv
`timescale 1ns/1ps

module lsu_props import lsu_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       flush_pipeline,
    input logic       mem_req,
    input logic       mem_we,
    input word_t      mem_addr,
    input word_t      mem_wdata,
    input logic       mem_ready,
    input logic       cdb_valid,
    input logic       lsu_exception,
    input exc_cause_t lsu_exception_cause
);

    // Count of failed assertions
    int failures = 0;

    // Request fields hold until the memory accepts
    assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ready |=> mem_req && $stable(mem_addr) && $stable(mem_we)
                                  && $stable(mem_wdata))
        else begin
            failures++;
            $error("memory request changed before mem_ready");
        end

    assert property (@(posedge clk) disable iff (reset)
        flush_pipeline |=> !cdb_valid)
        else begin
            failures++;
            $error("CDB pulse in the cycle after a flush");
        end

    assert property (@(posedge clk) disable iff (reset)
        lsu_exception |-> lsu_exception_cause != CAUSE_NONE)
        else begin
            failures++;
            $error("exception raised without a cause");
        end

endmodule

bind lsu lsu_props u_props (
    .clk                 (clk),
    .reset               (reset),
    .flush_pipeline      (flush_pipeline),
    .mem_req             (mem_req),
    .mem_we              (mem_we),
    .mem_addr            (mem_addr),
    .mem_wdata           (mem_wdata),
    .mem_ready           (mem_ready),
    .cdb_valid           (cdb_valid),
    .lsu_exception       (lsu_exception),
    .lsu_exception_cause (lsu_exception_cause)
);

// File: verif/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;
    import lsu_pkg::*;

    localparam int    LQ_DEPTH = 8;
    localparam int    TIMEOUT  = 200;
    localparam word_t ERR_ADDR = 32'h0000_0ff0;

    logic       clk;
    logic       reset;
    logic       flush_pipeline;
    logic       alloc_valid;
    logic       alloc_ready;
    logic       is_load;
    word_t      base_addr;
    word_t      offset;
    phys_tag_t  phys_rd;
    rob_idx_t   rob_idx;
    word_t      store_data;
    logic       commit_en;
    rob_idx_t   commit_rob_idx;
    logic       cdb_valid;
    phys_tag_t  cdb_tag;
    word_t      cdb_value;
    logic       cdb_exception;
    logic       lsu_exception;
    exc_cause_t lsu_exception_cause;
    logic       mem_req;
    logic       mem_we;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic       mem_ready;
    word_t      mem_rdata;
    logic       mem_error;

    // Memory model state
    word_t       mem_model [0:1023];
    logic        mem_stall;
    logic        mem_busy;
    int          wait_left;
    int          access_count;
    logic [31:0] rng_state;
    word_t       write_addr_q [$];
    word_t       write_data_q [$];

    // Observed results
    phys_tag_t cdb_tag_q [$];
    word_t     cdb_val_q [$];
    logic      cdb_exc_q [$];
    int        exc_count;
    int        checks;
    int        errors;

    lsu DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Preload pattern, unique per word address
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    // ============================================================
    // Memory model, 0 to 3 idle cycles per access
    // ============================================================
    always @(posedge clk) begin
        #1;
        if (mem_ready) begin
            mem_ready = 1'b0;
            mem_error = 1'b0;
            mem_busy  = 1'b0;
        end else if (mem_req && !reset) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                rng_state = xorshift32(rng_state);
                wait_left = rng_state % 4;
                access_count++;
            end
            if (wait_left == 0 && !mem_stall) begin
                mem_ready = 1'b1;
                if (mem_we) begin
                    mem_model[mem_addr[11:2]] = mem_wdata;
                    write_addr_q.push_back(mem_addr);
                    write_data_q.push_back(mem_wdata);
                end else begin
                    mem_rdata = mem_model[mem_addr[11:2]];
                    mem_error = (mem_addr == ERR_ADDR);
                end
            end else if (wait_left != 0) begin
                wait_left--;
            end
        end
    end

    // CDB and exception monitors, sampled mid-cycle
    always @(negedge clk) begin
        if (cdb_valid) begin
            cdb_tag_q.push_back(cdb_tag);
            cdb_val_q.push_back(cdb_value);
            cdb_exc_q.push_back(cdb_exception);
        end
        if (lsu_exception) begin
            exc_count++;
        end
    end

    // ============================================================
    // Check and stimulus helpers
    // ============================================================
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, msg);
        end
    endtask

    task automatic check_cdb(input int i, input phys_tag_t tag, input word_t value,
                             input logic exc);
        check_word("cdb_tag", word_t'(cdb_tag_q[i]), word_t'(tag));
        check_word("cdb_exception", word_t'(cdb_exc_q[i]), word_t'(exc));
        if (!exc) begin
            check_word("cdb_value", cdb_val_q[i], value);
        end
    endtask

    task automatic clear_logs();
        cdb_tag_q.delete();
        cdb_val_q.delete();
        cdb_exc_q.delete();
        write_addr_q.delete();
        write_data_q.delete();
    endtask

    task automatic drive_alloc(input logic ld, input word_t base, input word_t off,
                               input phys_tag_t tag, input rob_idx_t rob, input word_t data);
        alloc_valid = 1'b1;
        is_load     = ld;
        base_addr   = base;
        offset      = off;
        phys_rd     = tag;
        rob_idx     = rob;
        store_data  = data;
    endtask

    // Returns 1 ns after the handshake edge
    task automatic wait_handshake();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!alloc_ready && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        check_true(alloc_ready, "allocation was never accepted");
        @(posedge clk);
        #1;
        alloc_valid = 1'b0;
    endtask

    task automatic alloc_op(input logic ld, input word_t base, input word_t off,
                            input phys_tag_t tag, input rob_idx_t rob, input word_t data);
        drive_alloc(ld, base, off, tag, rob, data);
        wait_handshake();
    endtask

    task automatic commit_store(input rob_idx_t rob);
        commit_en      = 1'b1;
        commit_rob_idx = rob;
        @(posedge clk);
        #1;
        commit_en = 1'b0;
    endtask

    task automatic pulse_flush();
        flush_pipeline = 1'b1;
        @(posedge clk);
        #1;
        flush_pipeline = 1'b0;
    endtask

    // Fixed quiet window, used where absence of activity is checked
    task automatic settle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_cdb(input int n);
        int waited;
        waited = 0;
        while (cdb_tag_q.size() < n && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        check_true(cdb_tag_q.size() >= n, "timeout waiting for CDB results");
    endtask

    task automatic wait_writes(input int n);
        int waited;
        waited = 0;
        while (write_addr_q.size() < n && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        check_true(write_addr_q.size() >= n, "timeout waiting for memory writes");
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic test_loads();
        clear_logs();
        for (int i = 0; i < 4; i++) begin
            alloc_op(1'b1, 32'h100, word_t'(i * 4), phys_tag_t'(i + 1), '0, '0);
        end
        alloc_op(1'b1, ERR_ADDR - 32'h10, 32'h10, 6'd5, '0, '0);
        wait_cdb(5);
        for (int i = 0; i < 4; i++) begin
            check_cdb(i, phys_tag_t'(i + 1), fill_word(32'h100 + i * 4), 1'b0);
        end
        check_cdb(4, 6'd5, '0, 1'b1);
    endtask

    task automatic test_stores();
        clear_logs();
        alloc_op(1'b0, 32'h200, 32'h0, '0, 6'd10, 32'hdead_beef);
        alloc_op(1'b0, 32'h1f0, 32'h14, '0, 6'd11, 32'h0bad_f00d);
        commit_store(6'd10);
        wait_writes(1);
        settle(20);
        // Uncommitted store is dropped by the flush
        pulse_flush();
        settle(10);
        check_word("write count", word_t'(write_addr_q.size()), 32'd1);
        check_word("mem_addr", write_addr_q[0], 32'h200);
        check_word("mem_wdata", write_data_q[0], 32'hdead_beef);
    endtask

    task automatic test_forwarding();
        clear_logs();
        // A stalled read keeps both committed stores in the queue
        mem_stall = 1'b1;
        alloc_op(1'b1, 32'h310, 32'h0, 6'd6, '0, '0);
        alloc_op(1'b0, 32'h300, 32'h0, '0, 6'd20, 32'h1234_0001);
        alloc_op(1'b0, 32'h300, 32'h0, '0, 6'd21, 32'h1234_0002);
        commit_store(6'd20);
        commit_store(6'd21);
        alloc_op(1'b1, 32'h300, 32'h0, 6'd7, '0, '0);
        mem_stall = 1'b0;
        alloc_op(1'b0, 32'h304, 32'h0, '0, 6'd22, 32'hcafe_0003);
        commit_store(6'd22);
        alloc_op(1'b1, 32'h300, 32'h4, 6'd8, '0, '0);
        wait_cdb(3);
        check_cdb(0, 6'd6, fill_word(32'h310), 1'b0);
        check_cdb(1, 6'd7, 32'h1234_0002, 1'b0);
        check_cdb(2, 6'd8, 32'hcafe_0003, 1'b0);
        wait_writes(3);
    endtask

    task automatic test_misaligned();
        int acc_before;
        clear_logs();
        settle(5);
        acc_before = access_count;
        exc_count  = 0;
        check_word("lsu_exception", word_t'(lsu_exception), 32'd0);
        alloc_op(1'b1, 32'h400, 32'h1, 6'd9, '0, '0);
        check_word("lsu_exception", word_t'(lsu_exception), 32'd1);
        check_word("lsu_exception_cause", word_t'(lsu_exception_cause),
                   word_t'(CAUSE_LOAD_MISALIGNED));
        settle(1);
        check_word("lsu_exception", word_t'(lsu_exception), 32'd0);
        alloc_op(1'b0, 32'h402, 32'h0, '0, 6'd23, 32'h5555_5555);
        check_word("lsu_exception", word_t'(lsu_exception), 32'd1);
        check_word("lsu_exception_cause", word_t'(lsu_exception_cause),
                   word_t'(CAUSE_STORE_MISALIGNED));
        settle(20);
        check_word("exception pulses", word_t'(exc_count), 32'd2);
        check_word("memory accesses", word_t'(access_count - acc_before), 32'd0);
        check_word("cdb pulses", word_t'(cdb_tag_q.size()), 32'd0);
    endtask

    task automatic test_flush();
        clear_logs();
        mem_stall = 1'b1;
        alloc_op(1'b1, 32'h600, 32'h0, 6'd10, '0, '0);
        alloc_op(1'b0, 32'h500, 32'h0, '0, 6'd30, 32'h1111_aaaa);
        commit_store(6'd30);
        alloc_op(1'b0, 32'h508, 32'h0, '0, 6'd32, 32'h2222_bbbb);
        commit_store(6'd32);
        alloc_op(1'b0, 32'h504, 32'h0, '0, 6'd31, 32'h3333_cccc);
        alloc_op(1'b1, 32'h604, 32'h0, 6'd11, '0, '0);
        pulse_flush();
        mem_stall = 1'b0;
        wait_writes(2);
        settle(30);
        check_word("cdb pulses", word_t'(cdb_tag_q.size()), 32'd0);
        check_word("write count", word_t'(write_addr_q.size()), 32'd2);
        check_word("mem_addr", write_addr_q[0], 32'h500);
        check_word("mem_wdata", write_data_q[0], 32'h1111_aaaa);
        check_word("mem_addr", write_addr_q[1], 32'h508);
        check_word("mem_wdata", write_data_q[1], 32'h2222_bbbb);
        // Loads after the flush
        alloc_op(1'b1, 32'h4f0, 32'h10, 6'd12, '0, '0);
        alloc_op(1'b1, 32'h608, 32'h0, 6'd13, '0, '0);
        wait_cdb(2);
        check_cdb(0, 6'd12, 32'h1111_aaaa, 1'b0);
        check_cdb(1, 6'd13, fill_word(32'h608), 1'b0);
    endtask

    task automatic test_backpressure();
        clear_logs();
        mem_stall = 1'b1;
        for (int i = 0; i < LQ_DEPTH; i++) begin
            alloc_op(1'b1, 32'h700, word_t'(i * 4), phys_tag_t'(i + 20), '0, '0);
        end
        drive_alloc(1'b1, 32'h700, word_t'(LQ_DEPTH * 4), phys_tag_t'(LQ_DEPTH + 20), '0, '0);
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            check_word("alloc_ready", word_t'(alloc_ready), 32'd0);
        end
        @(posedge clk);
        #1;
        mem_stall = 1'b0;
        wait_handshake();
        wait_cdb(LQ_DEPTH + 1);
        for (int i = 0; i <= LQ_DEPTH; i++) begin
            check_cdb(i, phys_tag_t'(i + 20), fill_word(32'h700 + i * 4), 1'b0);
        end
    endtask

    initial begin
        clk            = 1'b0;
        reset          = 1'b1;
        flush_pipeline = 1'b0;
        alloc_valid    = 1'b0;
        is_load        = 1'b0;
        base_addr      = '0;
        offset         = '0;
        phys_rd        = '0;
        rob_idx        = '0;
        store_data     = '0;
        commit_en      = 1'b0;
        commit_rob_idx = '0;
        mem_ready      = 1'b0;
        mem_rdata      = '0;
        mem_error      = 1'b0;
        mem_stall      = 1'b0;
        mem_busy       = 1'b0;
        wait_left      = 0;
        access_count   = 0;
        rng_state      = 32'he09a87f2;
        exc_count      = 0;
        checks         = 0;
        errors         = 0;
        for (int i = 0; i < 1024; i++) begin
            mem_model[i] = fill_word(word_t'(i * 4));
        end

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        settle(2);

        test_loads();
        test_stores();
        test_forwarding();
        test_misaligned();
        test_flush();
        test_backpressure();
        settle(5);

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, DUT.u_props.failures);
        if (errors == 0 && DUT.u_props.failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
